// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

    localparam int CLK_PER_BIT = 16;                   // Clocks per serial bit.
    localparam int CTR_W       = $clog2(CLK_PER_BIT);  // Bit-period counter width.

    localparam int FIFO_DEPTH = 8;  // Receive FIFO entries.
    localparam int FIFO_AW    = 3;  // Pointer width, depth is a power of two.

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_WAIT_HALF,
        RX_WAIT_FULL,
        RX_WAIT_HIGH
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

// File: source/uart_rx.sv
`default_nettype none

module uart_rx (
    input  wire        clk,
    input  wire        rst,
    input  wire        rxd,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);

    uart_pkg::rx_state_t        state_d, state_q;
    logic [uart_pkg::CTR_W-1:0] ctr_d, ctr_q;
    logic [2:0]                 bit_ctr_d, bit_ctr_q;
    logic [7:0]                 data_d, data_q;
    logic                       strobe_d;
    logic                       rxd_q;

    assign rx_byte = data_q;

    always_comb begin
        state_d   = state_q;
        ctr_d     = ctr_q;
        bit_ctr_d = bit_ctr_q;
        data_d    = data_q;
        strobe_d  = 1'b0;

        case (state_q)
            uart_pkg::RX_IDLE: begin
                ctr_d     = '0;
                bit_ctr_d = '0;
                if (!rxd_q) begin  // Falling edge of start bit.
                    state_d = uart_pkg::RX_WAIT_HALF;
                end
            end
            uart_pkg::RX_WAIT_HALF: begin
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == (uart_pkg::CLK_PER_BIT >> 1)) begin  // Middle of start bit.
                    ctr_d   = '0;
                    state_d = uart_pkg::RX_WAIT_FULL;
                end
            end
            uart_pkg::RX_WAIT_FULL: begin
                ctr_d = ctr_q + 1'b1;
                if (ctr_q == uart_pkg::CLK_PER_BIT - 1) begin
                    data_d    = {rxd_q, data_q[7:1]};  // LSB arrives first.
                    bit_ctr_d = bit_ctr_q + 1'b1;
                    ctr_d     = '0;
                    if (bit_ctr_q == 3'd7) begin
                        strobe_d = 1'b1;
                        state_d  = uart_pkg::RX_WAIT_HIGH;
                    end
                end
            end
            uart_pkg::RX_WAIT_HIGH: begin
                // Hold off until the stop bit brings the line back to idle.
                if (rxd_q) begin
                    state_d = uart_pkg::RX_IDLE;
                end
            end
            default: begin
                state_d = uart_pkg::RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= uart_pkg::RX_IDLE;
            ctr_q     <= '0;
            bit_ctr_q <= '0;
            rx_strobe <= 1'b0;
            rxd_q     <= 1'b1;  // Line idles high.
        end else begin
            state_q   <= state_d;
            ctr_q     <= ctr_d;
            bit_ctr_q <= bit_ctr_d;
            rx_strobe <= strobe_d;
            rxd_q     <= rxd;
        end
        data_q <= data_d;
    end

    a_strobe_single: assert property (@(posedge clk) disable iff (rst)
        rx_strobe |=> !rx_strobe)
        else $error("uart_rx: rx_strobe held for more than one cycle");

    a_half_bound: assert property (@(posedge clk) disable iff (rst)
        (state_q == uart_pkg::RX_WAIT_HALF) |-> (ctr_q <= (uart_pkg::CLK_PER_BIT >> 1)))
        else $error("uart_rx: half-bit counter ran past the middle of the start bit");

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`default_nettype none

module uart_tx (
    input  wire       clk,
    input  wire       rst,
    input  wire [7:0] tx_data,
    input  wire       tx_start,
    output logic      txd,
    output logic      tx_busy
);

    uart_pkg::tx_state_t        state_d, state_q;
    logic [uart_pkg::CTR_W-1:0] ctr_d, ctr_q;
    logic [2:0]                 bit_ctr_d, bit_ctr_q;
    logic [8:0]                 shift_d, shift_q;  // Start bit plus data, shifted right.
    logic                       bit_end;

    assign bit_end = (ctr_q == uart_pkg::CLK_PER_BIT - 1);
    assign txd     = shift_q[0];
    assign tx_busy = (state_q != uart_pkg::TX_IDLE);

    always_comb begin
        state_d   = state_q;
        ctr_d     = ctr_q;
        bit_ctr_d = bit_ctr_q;
        shift_d   = shift_q;

        if (state_q != uart_pkg::TX_IDLE) begin
            ctr_d = bit_end ? '0 : ctr_q + 1'b1;
            if (bit_end) begin
                shift_d = {1'b1, shift_q[8:1]};  // Ones fill in behind, giving the stop bit.
            end
        end

        case (state_q)
            uart_pkg::TX_IDLE: begin
                ctr_d     = '0;
                bit_ctr_d = '0;
                if (tx_start) begin
                    shift_d = {tx_data, 1'b0};
                    state_d = uart_pkg::TX_START;
                end
            end
            uart_pkg::TX_START: begin
                if (bit_end) begin
                    state_d = uart_pkg::TX_DATA;
                end
            end
            uart_pkg::TX_DATA: begin
                if (bit_end) begin
                    bit_ctr_d = bit_ctr_q + 1'b1;
                    if (bit_ctr_q == 3'd7) begin
                        state_d = uart_pkg::TX_STOP;
                    end
                end
            end
            uart_pkg::TX_STOP: begin
                if (bit_end) begin
                    state_d = uart_pkg::TX_IDLE;  // Busy drops on the next cycle.
                end
            end
            default: begin
                state_d = uart_pkg::TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= uart_pkg::TX_IDLE;
            ctr_q     <= '0;
            bit_ctr_q <= '0;
            shift_q   <= '1;  // Keeps txd high out of reset.
        end else begin
            state_q   <= state_d;
            ctr_q     <= ctr_d;
            bit_ctr_q <= bit_ctr_d;
            shift_q   <= shift_d;
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (rst)
        (state_q == uart_pkg::TX_IDLE) |-> txd)
        else $error("uart_tx: txd low while idle");

endmodule

`default_nettype wire

// File: source/rx_fifo.sv
`default_nettype none

module rx_fifo (
    input  wire        clk,
    input  wire        rst,
    input  wire        wr,
    input  wire  [7:0] wr_data,
    input  wire        rd,
    output logic [7:0] rd_data,
    output logic       empty,
    output logic       full,
    output logic       overrun
);

    logic [7:0]                   mem [uart_pkg::FIFO_DEPTH];
    logic [uart_pkg::FIFO_AW-1:0] wr_ptr, rd_ptr;
    logic [uart_pkg::FIFO_AW:0]   count;
    logic                         do_push;
    logic                         do_pop;

    assign empty   = (count == '0);
    assign full    = (count == uart_pkg::FIFO_DEPTH);
    assign rd_data = mem[rd_ptr];  // Head entry, always visible.

    assign do_pop  = rd && !empty;
    assign do_push = wr && (!full || do_pop);  // A pop in the same cycle frees a slot.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // Sticky, cleared only by reset.
            if (wr && !do_push) begin
                overrun <= 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= uart_pkg::FIFO_DEPTH)
        else $error("rx_fifo: count above depth");

endmodule

`default_nettype wire

// File: source/uart_link.sv
`default_nettype none

module uart_link (
    input  wire        clk,
    input  wire        rst,
    input  wire        rxd,
    output logic       txd,
    input  wire  [7:0] tx_data,
    input  wire        tx_start,
    output logic       tx_busy,
    input  wire        rd,
    output logic [7:0] rd_data,
    output logic       rx_empty,
    output logic       rx_full,
    output logic       overrun
);

    logic [7:0] rx_byte;
    logic       rx_strobe;  // One cycle per received byte.

    uart_rx i_uart_rx (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

    rx_fifo i_rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr      (rx_strobe),
        .wr_data (rx_byte),
        .rd      (rd),
        .rd_data (rd_data),
        .empty   (rx_empty),
        .full    (rx_full),
        .overrun (overrun)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// File: sim/tb_uart_link.sv
`default_nettype none

module tb_uart_link;

    localparam int BIT_CYC        = uart_pkg::CLK_PER_BIT;
    localparam int NUM_FRAMES     = 20 + 20 + 10 + 12;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 11 * BIT_CYC + 2000;
    localparam int WAIT_LIMIT     = 12 * BIT_CYC;

    logic       clk;
    logic       rst;
    logic       rxd_drv;
    logic       loopback;
    logic       dut_rxd;
    logic       txd;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       rd;
    logic [7:0] rd_data;
    logic       rx_empty;
    logic       rx_full;
    logic       overrun;

    logic [15:0] lfsr = 16'd69;
    logic [7:0]  model_q[$];  // Expected FIFO contents.
    logic        model_overrun = 1'b0;
    logic [7:0]  mon_q[$];    // Bytes decoded from txd.
    int          mon_frames = 0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;

    assign dut_rxd = loopback ? txd : rxd_drv;  // Loopback mux.

    uart_link i_uart_link (
        .clk      (clk),
        .rst      (rst),
        .rxd      (dut_rxd),
        .txd      (txd),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .rd       (rd),
        .rd_data  (rd_data),
        .rx_empty (rx_empty),
        .rx_full  (rx_full),
        .overrun  (overrun)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // Taps 16, 14, 13, 11.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %0h got %0h", $time, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("PASS: %s", name);
            tests_passed++;
        end else begin
            $display("FAIL: %s with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    task automatic model_push(input logic [7:0] b);
        if (model_q.size() == uart_pkg::FIFO_DEPTH) begin
            model_overrun = 1'b1;  // Byte is dropped.
        end else begin
            model_q.push_back(b);
        end
    endtask

    // One 8N1 frame on rxd with the LSB first.
    task automatic send_frame(input logic [7:0] b);
        rxd_drv = 1'b0;
        repeat (BIT_CYC) @(negedge clk);
        for (int k = 0; k < 8; k++) begin
            rxd_drv = b[k];
            repeat (BIT_CYC) @(negedge clk);
        end
        rxd_drv = 1'b1;
        repeat (BIT_CYC) @(negedge clk);
    endtask

    task automatic wait_not_empty();
        int n;
        n = 0;
        while (rx_empty && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rx_empty) begin
            $display("Receive FIFO stayed empty for %0d cycles at %0t", n, $time);
            errors++;
        end
    endtask

    task automatic pop_and_check();
        logic [7:0] expected;
        if (model_q.size() == 0) begin
            $display("Read attempted with no byte expected at %0t", $time);
            errors++;
        end else begin
            expected = model_q.pop_front();
            wait_not_empty();
            check_value(rd_data, expected, "rd_data");
            rd = 1'b1;
            @(negedge clk);
            rd = 1'b0;
        end
    endtask

    // Starts one frame, optionally pokes tx_start while busy, waits for idle.
    task automatic transmit_byte(input logic [7:0] b, input logic poke, input int poke_at);
        int busy_cycles;
        busy_cycles = 0;
        tx_data     = b;
        tx_start    = 1'b1;
        @(negedge clk);
        tx_start = 1'b0;
        check_value(tx_busy, 1'b1, "tx_busy after tx_start");
        while (tx_busy && busy_cycles < WAIT_LIMIT) begin
            tx_start = poke && (busy_cycles == poke_at);
            tx_data  = ~b;  // Must not reach the line.
            busy_cycles++;
            @(negedge clk);
        end
        tx_start = 1'b0;
        if (tx_busy) begin
            $display("Transmitter stayed busy for %0d cycles at %0t", busy_cycles, $time);
            errors++;
        end
        check_value(busy_cycles, 10 * BIT_CYC, "tx_busy length");
    endtask

    // Mid-bit decoder for txd.
    initial begin
        logic [7:0] mon_byte;
        forever begin
            @(negedge clk);
            if (!rst && !txd) begin
                repeat (BIT_CYC / 2) @(negedge clk);
                check_value(txd, 1'b0, "txd start bit");
                for (int k = 0; k < 8; k++) begin
                    repeat (BIT_CYC) @(negedge clk);
                    mon_byte[k] = txd;
                end
                repeat (BIT_CYC) @(negedge clk);
                check_value(txd, 1'b1, "txd stop bit");
                mon_q.push_back(mon_byte);
                mon_frames++;
            end
        end
    end

    initial begin
        logic [7:0] b;
        logic [7:0] exp_q[$];
        int         e0;
        int         frames0;
        clk      = 1'b0;
        rst      = 1'b1;
        rxd_drv  = 1'b1;
        loopback = 1'b0;
        tx_data  = '0;
        tx_start = 1'b0;
        rd       = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        e0 = errors;
        check_value(txd, 1'b1, "txd after reset");
        check_value(tx_busy, 1'b0, "tx_busy after reset");
        check_value(rx_empty, 1'b1, "rx_empty after reset");
        check_value(rx_full, 1'b0, "rx_full after reset");
        check_value(overrun, 1'b0, "overrun after reset");
        report_test("reset state", e0);

        e0 = errors;
        for (int n = 0; n < 20; n++) begin
            b = 8'(rand_bits(8));
            send_frame(b);
            model_push(b);
            pop_and_check();
            repeat (rand_bits(4)) @(negedge clk);  // Idle gap.
        end
        check_value(rx_empty, 1'b1, "rx_empty after receive");
        check_value(overrun, model_overrun, "overrun after receive");
        report_test("receive path", e0);

        e0 = errors;
        mon_q.delete();
        frames0 = mon_frames;
        for (int n = 0; n < 20; n++) begin
            b = 8'(rand_bits(8));
            exp_q.push_back(b);
            transmit_byte(b, 1'(rand_bits(1)), rand_bits(7));
        end
        check_value(mon_frames - frames0, 20, "frames on txd");
        for (int n = 0; n < exp_q.size() && n < mon_q.size(); n++) begin
            check_value(mon_q[n], exp_q[n], "byte decoded from txd");
        end
        report_test("transmit path", e0);

        e0 = errors;
        for (int n = 0; n < 10; n++) begin
            b = 8'(rand_bits(8));
            send_frame(b);
            model_push(b);
            if (n == 7) begin
                check_value(rx_full, 1'b1, "rx_full after eight bytes");
                check_value(overrun, 1'b0, "overrun after eight bytes");
            end
        end
        check_value(overrun, model_overrun, "overrun after ten bytes");
        while (model_q.size() > 0) begin
            pop_and_check();
        end
        check_value(rx_empty, 1'b1, "rx_empty after drain");
        check_value(rx_full, 1'b0, "rx_full after drain");
        report_test("fifo fill and overrun", e0);

        e0 = errors;
        loopback = 1'b1;
        for (int n = 0; n < 12; n++) begin
            b = 8'(rand_bits(8));
            transmit_byte(b, 1'b0, 0);
            model_push(b);
            if (rand_bits(1) || model_q.size() >= 6) begin
                while (model_q.size() > 0) begin
                    pop_and_check();
                end
            end
        end
        while (model_q.size() > 0) begin
            pop_and_check();
        end
        loopback = 1'b0;
        check_value(rx_empty, 1'b1, "rx_empty after loopback");
        check_value(overrun, model_overrun, "overrun after loopback");
        report_test("loopback", e0);

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_link.f
source/uart_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/rx_fifo.sv
source/uart_link.sv
sim/tb_uart_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_uart_link -f uart_link.f

output=$(./obj_dir/Vtb_uart_link)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
